// ==== filelist.f ====
design/cpu_pkg.sv
design/core_pkg.sv
design/seq_if.sv
design/stack_ctrl.sv
design/stack_ptr.sv
design/push_pull_seq.sv
design/stack_mux.sv
design/reg_file.sv
design/stack_ram.sv
design/stack_unit.sv
testbench/tb_stack_unit.sv

// ==== Bender.yml ====
package:
  name: stack_unit

sources:
  - files:
      - design/cpu_pkg.sv
      - design/core_pkg.sv
      - design/seq_if.sv
      - design/stack_ctrl.sv
      - design/stack_ptr.sv
      - design/push_pull_seq.sv
      - design/stack_mux.sv
      - design/reg_file.sv
      - design/stack_ram.sv
      - design/stack_unit.sv
  - target: simulation
    files:
      - testbench/tb_stack_unit.sv

// ==== testbench/tb_stack_unit.sv ====
// Self-checking testbench for the stack unit.
// a reference model of the registers, both pointers and a 64K memory image
// predicts every push write and every pulled register.
`default_nettype none

module tb_stack_unit;

    localparam int MAX_WAIT = 400;            // cycles allowed per instruction.

    logic        clk, rst, cen, start, reg_we;
    logic [7:0]  op, postbyte, mem_wdata;
    logic [3:0]  reg_sel;
    logic [15:0] reg_wdata, reg_rdata, mem_addr;
    logic        busy, done, mem_we;

    logic [15:0] model_reg [9];               // indexed by register id, s is id 8.
    logic [7:0]  model_mem [65536];           // byte image of the whole address space.
    logic [23:0] exp_wr [$];                  // address and byte of each expected write.
    logic [31:0] rng;
    logic        cen_rand;                    // drop cen at random while an op runs.
    logic [15:0] rd_val;
    logic [7:0]  pb;
    logic        user;

    string reg_name [9] = '{"cc", "a", "b", "dp", "x", "y", "u", "pc", "s"};

    stack_unit dut0 (
        .clk, .rst, .cen, .start, .op, .postbyte, .reg_we, .reg_sel, .reg_wdata,
        .reg_rdata, .busy, .done, .mem_we, .mem_addr, .mem_wdata
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // ========================================================================
    // reference model
    // ========================================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] r;
        r = x ^ (x << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    // bits 7 to 4 name 16-bit registers and cost two memory steps.
    function automatic int byte_count(input logic [7:0] mask);
        int n;
        n = 0;
        for (int i = 0; i < 8; i++) begin
            if (mask[i]) n += (i >= cpu_pkg::PB_X) ? 2 : 1;
        end
        return n;
    endfunction

    // bit 6 names the pointer of the stack that does not move.
    function automatic int reg_of_bit(input int i, input logic usr);
        if (i == cpu_pkg::PB_SU) return usr ? 8 : 6;
        return i;
    endfunction

    task automatic model_push(input logic usr, input logic [7:0] mask);
        int          sp;
        logic [15:0] v;
        sp = usr ? 6 : 8;
        for (int i = 7; i >= 0; i--) begin     // pc first, cc last.
            if (mask[i]) begin
                v = model_reg[reg_of_bit(i, usr)];
                model_reg[sp] = model_reg[sp] - 16'd1;   // decrement, then write.
                model_mem[model_reg[sp]] = v[7:0];
                exp_wr.push_back({model_reg[sp], v[7:0]});
                if (i >= cpu_pkg::PB_X) begin
                    model_reg[sp] = model_reg[sp] - 16'd1;
                    model_mem[model_reg[sp]] = v[15:8];     // high byte ends lower.
                    exp_wr.push_back({model_reg[sp], v[15:8]});
                end
            end
        end
    endtask

    task automatic model_pull(input logic usr, input logic [7:0] mask);
        int          sp;
        logic [15:0] v;
        sp = usr ? 6 : 8;
        for (int i = 0; i < 8; i++) begin      // cc first, pc last.
            if (mask[i]) begin
                if (i >= cpu_pkg::PB_X) begin
                    v[15:8] = model_mem[model_reg[sp]];
                    model_reg[sp] = model_reg[sp] + 16'd1;
                    v[7:0] = model_mem[model_reg[sp]];
                end else begin
                    v = {8'h00, model_mem[model_reg[sp]]};
                end
                model_reg[sp] = model_reg[sp] + 16'd1;   // read, then increment.
                model_reg[reg_of_bit(i, usr)] = v;
            end
        end
    endtask

    // ========================================================================
    // checks and port access
    // ========================================================================
    task automatic fail_with(input string what);
        $display("%s at time %0t", what, $time);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
        assert (act === exp) else begin
            $display("error at time %0t: %s expected %h, got %h", $time, name, exp, act);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic write_reg(input int id, input logic [15:0] val);
        @(negedge clk);
        reg_we    = 1'b1;
        reg_sel   = id[3:0];
        reg_wdata = val;
        model_reg[id] = (id <= 3) ? {8'h00, val[7:0]} : val;   // byte registers.
        @(negedge clk);
        reg_we = 1'b0;
    endtask

    // the read port is combinational, so the value settles a full cycle.
    task automatic read_reg(input int id, output logic [15:0] val);
        @(negedge clk);
        reg_sel = id[3:0];
        @(negedge clk);
        val = reg_rdata;
    endtask

    task automatic compare_all();
        logic [15:0] v;
        for (int id = 0; id < 9; id++) begin
            read_reg(id, v);
            check_val({"reg_rdata ", reg_name[id]}, model_reg[id], v);
        end
    endtask

    // s and u stay put, so the stacks never leave their own part of the ram.
    task automatic load_random(input logic [7:0] cc_mask);
        for (int id = 0; id < 8; id++) begin
            rng = xorshift32(rng);
            if (id == 0) write_reg(id, {8'h00, rng[7:0] & cc_mask});
            else if (id != 6) write_reg(id, rng[15:0]);
        end
    endtask

    // everything but the pointer of the stack in use goes to zero,
    // so the pointer that bit 6 restores starts cleared as well.
    task automatic clear_regs(input logic usr);
        for (int id = 0; id < 9; id++) begin
            if (id != (usr ? 6 : 8)) write_reg(id, 16'h0000);
        end
    endtask

    // ========================================================================
    // instruction runner
    // ========================================================================
    // one start pulse, then every enabled cycle is counted up to done.
    // a latency of zero leaves the count unchecked.
    task automatic run_op(input logic [7:0] opc, input logic [7:0] mask, input int lat);
        int          en_cycles;
        int          waited;
        logic [23:0] w;
        en_cycles = 0;
        waited    = 0;
        @(negedge clk);
        op       = opc;                  // op and postbyte stay until the next op.
        postbyte = mask;
        start    = 1'b1;
        cen      = 1'b1;
        do begin
            @(negedge clk);
            start = 1'b0;
            rng   = xorshift32(rng);
            cen   = !(cen_rand && rng[1:0] == 2'b00);
            #1;                          // outputs follow the new cen.
            if (cen) en_cycles++;
            if (mem_we) begin
                assert (exp_wr.size() > 0) else fail_with("memory write with no byte left");
                w = exp_wr.pop_front();
                check_val("mem_addr", w[23:8], mem_addr);
                check_val("mem_wdata", {8'h00, w[7:0]}, {8'h00, mem_wdata});
            end
            waited++;
            assert (waited < MAX_WAIT) else fail_with("done never arrived");
        end while (!done);
        // done needs cen, so cen is high again from here on.
        assert (exp_wr.size() == 0) else fail_with("fewer push writes than the postbyte names");
        if (lat != 0) check_val("done latency", lat[15:0], en_cycles[15:0]);
    endtask

    task automatic push_regs(input logic usr, input logic [7:0] mask);
        model_push(usr, mask);
        run_op(usr ? cpu_pkg::OP_PSHU : cpu_pkg::OP_PSHS, mask, byte_count(mask) + 3);
    endtask

    task automatic pull_regs(input logic usr, input logic [7:0] mask);
        model_pull(usr, mask);
        run_op(usr ? cpu_pkg::OP_PULU : cpu_pkg::OP_PULS, mask, byte_count(mask) + 3);
    endtask

    task automatic swi_frame();
        model_reg[0][cpu_pkg::CC_E] = 1'b1;           // e goes in before the frame.
        model_push(1'b0, cpu_pkg::PB_ALL);
        run_op(cpu_pkg::OP_SWI, 8'h00, byte_count(cpu_pkg::PB_ALL) + 4);
    endtask

    // cc comes off first and its e bit picks the rest of the frame.
    task automatic rti_frame();
        model_pull(1'b0, 8'h01);
        model_pull(1'b0, model_reg[0][cpu_pkg::CC_E] ? cpu_pkg::PB_NOT_CC
                                                     : cpu_pkg::PB_ONLY_PC);
        run_op(cpu_pkg::OP_RTI, 8'h00, 0);
    endtask

    // ========================================================================
    // test sequence
    // ========================================================================
    initial begin
        rst       = 1'b1;
        cen       = 1'b1;
        start     = 1'b0;
        op        = 8'h00;
        postbyte  = 8'h00;
        reg_we    = 1'b0;
        reg_sel   = 4'h0;
        reg_wdata = 16'h0000;
        cen_rand  = 1'b0;
        rng       = 32'hf9c0_83bf;
        for (int id = 0; id < 9; id++) model_reg[id] = 16'h0000;
        model_reg[8] = core_pkg::S_RESET;
        model_reg[6] = core_pkg::U_RESET;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        // reset state.
        check_val("busy", 16'h0000, {15'h0000, busy});
        check_val("done", 16'h0000, {15'h0000, done});
        check_val("mem_we", 16'h0000, {15'h0000, mem_we});
        compare_all();

        // pshs of random registers, then puls into cleared ones.
        load_random(8'hFF);
        rng = xorshift32(rng);
        pb  = rng[7:0] | 8'h41;          // u and cc always go along.
        push_regs(1'b0, pb);
        read_reg(8, rd_val);
        check_val("s after pshs", core_pkg::S_RESET - 16'(byte_count(pb)), rd_val);
        compare_all();
        clear_regs(1'b0);
        pull_regs(1'b0, pb);
        read_reg(8, rd_val);
        check_val("s after puls", core_pkg::S_RESET, rd_val);
        compare_all();
        pull_regs(1'b0, 8'h00);          // an empty mask only waits for done.

        // pshu and pulu move u and carry s through bit 6.
        load_random(8'hFF);
        rng = xorshift32(rng);
        pb  = rng[7:0] | 8'h40;
        push_regs(1'b1, pb);
        compare_all();
        clear_regs(1'b1);
        pull_regs(1'b1, pb);
        compare_all();

        // full frame from swi, then a short frame pushed with e clear.
        load_random(8'h7F);
        swi_frame();
        clear_regs(1'b0);
        rti_frame();
        compare_all();
        load_random(8'h7F);
        push_regs(1'b0, cpu_pkg::PB_CC_PC);
        load_random(8'hFF);
        rti_frame();
        compare_all();

        // random pairs on both stacks with cen dropping out.
        cen_rand = 1'b1;
        repeat (16) begin
            rng  = xorshift32(rng);
            user = rng[8];
            pb   = rng[7:0];
            push_regs(user, pb);
            load_random(8'hFF);
            pull_regs(user, pb);
            compare_all();
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/stack_unit.sv ====
// Push/pull unit for a 6809-family core.
// runs pshs, pshu, puls, pulu, swi and rti against a small stack ram.
`default_nettype none

module stack_unit (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic        start,
    input  logic [7:0]  op,
    input  logic [7:0]  postbyte,
    input  logic        reg_we,
    input  logic [3:0]  reg_sel,
    input  logic [15:0] reg_wdata,
    output logic [15:0] reg_rdata,
    output logic        busy,
    output logic        done,
    output logic        mem_we,
    output logic [15:0] mem_addr,
    output logic [7:0]  mem_wdata
);

    // ========================================================================
    // internal nets
    // ========================================================================
    seq_if sif ();

    cpu_pkg::reg_id_e reg_id;
    logic             psh_go, pul_go, psh_all, rti_cc, rti_other;
    logic             set_e, cc_e, step;
    logic [15:0]      s_ptr, u_ptr;
    logic [7:0]       pull_data;           // byte read at the stack pointer.
    logic [7:0][15:0] regs_flat;

    assign reg_id = cpu_pkg::reg_id_e'(reg_sel);

    stack_ctrl u_ctrl (
        .clk, .rst, .cen, .start, .op, .cc_e, .seq_busy(sif.busy),
        .psh_go, .pul_go, .psh_all, .rti_cc, .rti_other, .set_e, .busy, .done
    );

    push_pull_seq u_seq (
        .clk, .rst, .cen, .op, .postdata(postbyte), .cc(regs_flat[cpu_pkg::PB_CC][7:0]),
        .psh_all, .rti_cc, .rti_other, .psh_go, .pul_go, .step, .seq(sif.seq_mp)
    );

    stack_mux u_mux (
        .cen, .seq(sif.pick_mp), .regs_flat, .s_ptr, .u_ptr, .step, .mem_wdata, .mem_we
    );

    stack_ptr u_ptr_blk (
        .clk, .rst, .cen, .seq(sif.pick_mp), .step, .pull_data, .s_ptr, .u_ptr,
        .addr(mem_addr), .reg_we, .reg_sel(reg_id), .reg_wdata
    );

    reg_file u_regs (
        .clk, .rst, .cen, .seq(sif.pick_mp), .step, .pull_data, .set_e, .reg_we,
        .reg_sel(reg_id), .reg_wdata, .s_ptr, .u_ptr, .reg_rdata, .regs_flat, .cc_e
    );

    // only the low pointer byte reaches the ram.
    stack_ram u_ram (
        .clk, .we(mem_we), .addr(mem_addr[core_pkg::STACK_AW-1:0]),
        .wdata(mem_wdata), .rdata(pull_data)
    );

endmodule

`default_nettype wire

// ==== design/stack_ram.sv ====
// Stack memory of the stack unit.
// clocked write, combinational read so a pull byte is ready in its own step.
`default_nettype none

module stack_ram (
    input  logic                          clk,
    input  logic                          we,
    input  logic [core_pkg::STACK_AW-1:0] addr,
    input  logic [7:0]                    wdata,
    output logic [7:0]                    rdata
);

    logic [7:0] mem [core_pkg::STACK_SIZE];

    always_ff @(posedge clk) begin
        if (we) mem[addr] <= wdata;   // we already carries the clock enable.
    end

    assign rdata = mem[addr];

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
// CPU register file for the stack unit.
// holds cc, a, b, dp, x, y and pc with direct access and byte-wise pull writes.
`default_nettype none

module reg_file (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    seq_if.pick_mp            seq,
    input  logic              step,
    input  logic [7:0]        pull_data,
    input  logic              set_e,
    input  logic              reg_we,
    input  cpu_pkg::reg_id_e  reg_sel,
    input  logic [15:0]       reg_wdata,
    input  logic [15:0]       s_ptr,
    input  logic [15:0]       u_ptr,
    output logic [15:0]       reg_rdata,
    output logic [7:0][15:0]  regs_flat,
    output logic              cc_e
);

    logic [7:0]  cc, a, b, dp;
    logic [15:0] x, y, pc;
    logic        pull_we;

    // places one pulled byte, high half on the first byte of the register.
    function automatic logic [15:0] put_byte(input logic [15:0] r, input logic [7:0] d,
                                             input logic hi);
        return hi ? {d, r[7:0]} : {r[15:8], d};
    endfunction

    assign pull_we = step && !seq.pshdec;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            {cc, a, b, dp} <= '0;
            {x, y, pc}     <= '0;
        end else if (cen) begin
            if (reg_we) begin
                case (reg_sel)
                    cpu_pkg::REG_CC: cc <= reg_wdata[7:0];
                    cpu_pkg::REG_A:  a  <= reg_wdata[7:0];
                    cpu_pkg::REG_B:  b  <= reg_wdata[7:0];
                    cpu_pkg::REG_DP: dp <= reg_wdata[7:0];
                    cpu_pkg::REG_X:  x  <= reg_wdata;
                    cpu_pkg::REG_Y:  y  <= reg_wdata;
                    cpu_pkg::REG_PC: pc <= reg_wdata;
                    default: ;                      // s and u live in the pointer block.
                endcase
            end else if (pull_we) begin
                case (1'b1)
                    seq.psh_bit[cpu_pkg::PB_CC]: cc <= pull_data;
                    seq.psh_bit[cpu_pkg::PB_A]:  a  <= pull_data;
                    seq.psh_bit[cpu_pkg::PB_B]:  b  <= pull_data;
                    seq.psh_bit[cpu_pkg::PB_DP]: dp <= pull_data;
                    seq.psh_bit[cpu_pkg::PB_X]:  x  <= put_byte(x, pull_data, seq.hi_lon);
                    seq.psh_bit[cpu_pkg::PB_Y]:  y  <= put_byte(y, pull_data, seq.hi_lon);
                    seq.psh_bit[cpu_pkg::PB_PC]: pc <= put_byte(pc, pull_data, seq.hi_lon);
                    default: ;                      // bit 6 goes to a pointer.
                endcase
            end
            if (set_e) cc[cpu_pkg::CC_E] <= 1'b1;   // swi marks a full frame.
        end
    end

    // slots follow the postbyte bits. slot 6 is filled in by the picker.
    always_comb begin
        regs_flat                  = '0;
        regs_flat[cpu_pkg::PB_CC]  = {8'h00, cc};
        regs_flat[cpu_pkg::PB_A]   = {8'h00, a};
        regs_flat[cpu_pkg::PB_B]   = {8'h00, b};
        regs_flat[cpu_pkg::PB_DP]  = {8'h00, dp};
        regs_flat[cpu_pkg::PB_X]   = x;
        regs_flat[cpu_pkg::PB_Y]   = y;
        regs_flat[cpu_pkg::PB_PC]  = pc;
    end

    always_comb begin
        case (reg_sel)
            cpu_pkg::REG_CC: reg_rdata = {8'h00, cc};
            cpu_pkg::REG_A:  reg_rdata = {8'h00, a};
            cpu_pkg::REG_B:  reg_rdata = {8'h00, b};
            cpu_pkg::REG_DP: reg_rdata = {8'h00, dp};
            cpu_pkg::REG_X:  reg_rdata = x;
            cpu_pkg::REG_Y:  reg_rdata = y;
            cpu_pkg::REG_U:  reg_rdata = u_ptr;
            cpu_pkg::REG_PC: reg_rdata = pc;
            cpu_pkg::REG_S:  reg_rdata = s_ptr;
            default:         reg_rdata = 16'h0000;
        endcase
    end

    assign cc_e = cc[cpu_pkg::CC_E];

endmodule

`default_nettype wire

// ==== design/stack_mux.sv ====
// Register picker and byte multiplexer for the stack unit.
// chooses the register served next and the byte it puts on the memory bus.
`default_nettype none

module stack_mux (
    input  logic              cen,
    seq_if.pick_mp            seq,
    input  logic [7:0][15:0]  regs_flat,
    input  logic [15:0]       s_ptr,
    input  logic [15:0]       u_ptr,
    output logic              step,
    output logic [7:0]        mem_wdata,
    output logic              mem_we
);

    logic [15:0] word;   // whole value of the served register.
    logic        wide;

    // pushes go from pc down to cc, pulls from cc up to pc.
    always_comb begin
        seq.psh_bit = 8'h00;
        if (seq.pshdec) begin
            for (int i = 0; i < 8; i++) begin
                if (seq.psh_sel[i]) begin
                    seq.psh_bit = 8'h01 << i;     // the last set bit found stays.
                end
            end
        end else begin
            seq.psh_bit = seq.psh_sel & (~seq.psh_sel + 8'h01);  // lowest set bit.
        end
    end

    always_comb begin
        word = 16'h0000;
        for (int i = 0; i < 8; i++) begin
            if (seq.psh_bit[i]) begin
                word = regs_flat[i];
            end
        end
        // bit 6 names the pointer of the stack not being moved.
        if (seq.psh_bit[cpu_pkg::PB_SU]) begin
            word = seq.us_sel ? s_ptr : u_ptr;
        end
    end

    assign wide = |seq.psh_bit[cpu_pkg::PB_PC:cpu_pkg::PB_X];

    // a push stores the low byte first, so it lands at the higher address.
    assign mem_wdata = (wide && !seq.hi_lon) ? word[15:8] : word[7:0];

    assign step   = cen && seq.busy;        // one memory access per enabled clock.
    assign mem_we = step && seq.pshdec;

endmodule

`default_nettype wire

// ==== design/push_pull_seq.sv ====
// Postbyte sequencer for push and pull.
// latches the register mask and clears it one served register at a time.
`default_nettype none

module push_pull_seq (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic [7:0] op,
    input  logic [7:0] postdata,
    input  logic [7:0] cc,
    input  logic       psh_all,
    input  logic       rti_cc,
    input  logic       rti_other,
    input  logic       psh_go,
    input  logic       pul_go,
    input  logic       step,
    seq_if.seq_mp      seq
);

    logic [7:0] postbyte;   // mask for the pass about to start.
    logic       wide;       // the served register has two bytes.

    assign seq.busy = (seq.psh_sel != 8'h00);
    assign wide     = |seq.psh_bit[cpu_pkg::PB_PC:cpu_pkg::PB_X];

    // fixed masks win over the postbyte from the instruction stream.
    always_comb begin
        if (rti_cc)         postbyte = 8'b1 << cpu_pkg::PB_CC;
        else if (rti_other) postbyte = cc[cpu_pkg::CC_E] ? cpu_pkg::PB_NOT_CC : cpu_pkg::PB_ONLY_PC;
        else if (psh_all)   postbyte = cc[cpu_pkg::CC_E] ? cpu_pkg::PB_ALL : cpu_pkg::PB_CC_PC;
        else                postbyte = postdata;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seq.psh_sel <= 8'h00;
            seq.hi_lon  <= 1'b0;
            seq.us_sel  <= 1'b0;
            seq.pshdec  <= 1'b0;
        end else if (cen) begin
            if (!seq.busy) begin
                if (psh_go || pul_go) begin
                    seq.psh_sel <= postbyte;
                    seq.us_sel  <= op[0];      // odd opcodes use the u stack.
                    seq.hi_lon  <= 1'b1;
                    seq.pshdec  <= psh_go;
                end
            end else if (step) begin
                if (wide && seq.hi_lon) begin
                    seq.hi_lon <= 1'b0;          // second byte of the same register.
                end else begin
                    seq.hi_lon  <= 1'b1;
                    seq.psh_sel <= seq.psh_sel & ~seq.psh_bit;  // register done.
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/stack_ptr.sv ====
// S and U stack pointers.
// pre-decrement on push bytes, post-increment on pull bytes, plus direct loads.
`default_nettype none

module stack_ptr (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    seq_if.pick_mp            seq,
    input  logic              step,
    input  logic [7:0]        pull_data,
    output logic [15:0]       s_ptr,
    output logic [15:0]       u_ptr,
    output logic [15:0]       addr,
    input  logic              reg_we,
    input  cpu_pkg::reg_id_e  reg_sel,
    input  logic [15:0]       reg_wdata
);

    logic [15:0] cur;          // pointer of the stack in use.
    logic [15:0] nxt;          // its value after this byte.
    logic        pull_other;   // bit 6 byte arriving from memory.

    assign cur  = seq.us_sel ? u_ptr : s_ptr;
    assign nxt  = seq.pshdec ? cur - 16'd1 : cur + 16'd1;
    assign addr = seq.pshdec ? nxt : cur;    // a push writes below the pointer.

    assign pull_other = step && !seq.pshdec && seq.psh_bit[cpu_pkg::PB_SU];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s_ptr <= core_pkg::S_RESET;
            u_ptr <= core_pkg::U_RESET;
        end else if (cen) begin
            if (reg_we && reg_sel == cpu_pkg::REG_S) s_ptr <= reg_wdata;
            if (reg_we && reg_sel == cpu_pkg::REG_U) u_ptr <= reg_wdata;
            if (step) begin
                if (seq.us_sel) u_ptr <= nxt;
                else            s_ptr <= nxt;
            end
            // the other pointer is restored a byte at a time, high byte first.
            if (pull_other) begin
                if (seq.us_sel) begin
                    if (seq.hi_lon) s_ptr[15:8] <= pull_data;
                    else            s_ptr[7:0]  <= pull_data;
                end else begin
                    if (seq.hi_lon) u_ptr[15:8] <= pull_data;
                    else            u_ptr[7:0]  <= pull_data;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/stack_ctrl.sv ====
// Stack instruction controller.
// decodes the opcode and runs one sequencer pass, or two for rti.
`default_nettype none

module stack_ctrl (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    input  logic       start,
    input  logic [7:0] op,
    input  logic       cc_e,
    input  logic       seq_busy,
    output logic       psh_go,
    output logic       pul_go,
    output logic       psh_all,
    output logic       rti_cc,
    output logic       rti_other,
    output logic       set_e,
    output logic       busy,
    output logic       done
);

    core_pkg::ctrl_state_e state;
    cpu_pkg::opcode_e      op_q;     // opcode latched on start.
    cpu_pkg::opcode_e      op_in;
    logic                  op_ok;    // start carries a stack opcode.
    logic                  is_push;

    assign op_in   = cpu_pkg::opcode_e'(op);
    assign is_push = (op_q == cpu_pkg::OP_PSHS) || (op_q == cpu_pkg::OP_PSHU) ||
                     (op_q == cpu_pkg::OP_SWI);

    always_comb begin
        case (op_in)
            cpu_pkg::OP_PSHS, cpu_pkg::OP_PSHU, cpu_pkg::OP_PULS,
            cpu_pkg::OP_PULU, cpu_pkg::OP_SWI, cpu_pkg::OP_RTI: op_ok = 1'b1;
            default: op_ok = 1'b0;      // other opcodes are left to the core.
        endcase
    end

    // ========================================================================
    // state sequence
    // ========================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= core_pkg::IDLE;
            op_q  <= cpu_pkg::OP_PSHS;
        end else if (cen) begin
            case (state)
                core_pkg::IDLE: begin
                    if (start && op_ok) begin   // a start while busy never gets here.
                        op_q  <= op_in;
                        state <= (op_in == cpu_pkg::OP_SWI) ? core_pkg::SETE : core_pkg::PASS1;
                    end
                end
                core_pkg::SETE:  state <= core_pkg::PASS1;   // e lands in cc here.
                core_pkg::PASS1: state <= core_pkg::WAIT1;   // sequencer loads its mask.
                core_pkg::WAIT1: begin
                    if (!seq_busy) begin
                        // rti goes back for the rest once cc has been pulled.
                        state <= (op_q == cpu_pkg::OP_RTI) ? core_pkg::PASS2 : core_pkg::FINISH;
                    end
                end
                core_pkg::PASS2: state <= core_pkg::WAIT2;
                core_pkg::WAIT2: begin
                    if (!seq_busy) begin
                        state <= core_pkg::FINISH;
                    end
                end
                default: state <= core_pkg::IDLE;          // finish lasts one cycle.
            endcase
        end
    end

    // strobes for the sequencer, all taken on an enabled clock.
    assign psh_go    = (state == core_pkg::PASS1) && is_push;
    assign pul_go    = ((state == core_pkg::PASS1) && !is_push) || (state == core_pkg::PASS2);
    assign psh_all   = (state == core_pkg::PASS1) && (op_q == cpu_pkg::OP_SWI);
    assign rti_cc    = (state == core_pkg::PASS1) && (op_q == cpu_pkg::OP_RTI);
    assign rti_other = (state == core_pkg::PASS2);   // reads the e bit just pulled.
    assign set_e     = (state == core_pkg::SETE) && !cc_e;  // only when e is still clear.
    assign busy      = (state != core_pkg::IDLE);
    assign done      = (state == core_pkg::FINISH) && cen;

endmodule

`default_nettype wire

// ==== design/seq_if.sv ====
// Link between the postbyte sequencer and the blocks that serve each byte.
// the sequencer owns the mask and byte phase, the picker owns the served bit.
`default_nettype none

interface seq_if;

    logic [7:0] psh_sel;    // bits still to be served.
    logic [7:0] psh_bit;    // one-hot bit served in this step.
    logic       hi_lon;     // first byte of a 16-bit register.
    logic       pshdec;     // high on a push, low on a pull.
    logic       us_sel;     // high when the user stack moves.
    logic       busy;       // mask not yet empty.

    modport seq_mp (output psh_sel, hi_lon, pshdec, us_sel, busy, input psh_bit);

    modport pick_mp (output psh_bit, input psh_sel, hi_lon, pshdec, us_sel, busy);

endinterface

`default_nettype wire

// ==== design/core_pkg.sv ====
// Implementation constants of the stack unit.
// controller states, stack memory size and pointer reset values.
`default_nettype none

package core_pkg;

    // controller states. sete only appears on swi, pass2 and wait2 on rti.
    typedef enum logic [2:0] {
        IDLE,
        SETE,
        PASS1,
        WAIT1,
        PASS2,
        WAIT2,
        FINISH
    } ctrl_state_e;

    localparam int STACK_AW   = 8;               // the ram sees the low pointer byte.
    localparam int STACK_SIZE = 1 << STACK_AW;   // bytes of stack memory.

    localparam logic [15:0] S_RESET = 16'h0100;  // system stack, top of the ram.
    localparam logic [15:0] U_RESET = 16'h0080;  // user stack, half way down.

endpackage

`default_nettype wire

// ==== design/cpu_pkg.sv ====
// 6809 instruction set definitions used by the stack unit.
// opcodes, condition code bits, postbyte bits and register ids.
`default_nettype none

package cpu_pkg;

    // stack opcodes. bit 0 selects the user stack.
    typedef enum logic [7:0] {
        OP_PSHS = 8'h08,
        OP_PSHU = 8'h09,
        OP_PULS = 8'h0A,
        OP_PULU = 8'h0B,
        OP_SWI  = 8'h0C,
        OP_RTI  = 8'h0E
    } opcode_e;

    localparam int CC_E = 7;               // entire state was stacked.
    localparam int CC_C = 0;               // carry.

    // postbyte bits, in pull order. bits 7 to 4 name 16-bit registers.
    localparam int PB_CC = 0;
    localparam int PB_A  = 1;
    localparam int PB_B  = 2;
    localparam int PB_DP = 3;
    localparam int PB_X  = 4;
    localparam int PB_Y  = 5;
    localparam int PB_SU = 6;              // the stack pointer not in use.
    localparam int PB_PC = 7;

    localparam logic [7:0] PB_ALL     = 8'hFF;  // swi with e set.
    localparam logic [7:0] PB_CC_PC   = 8'h81;  // swi with e clear.
    localparam logic [7:0] PB_NOT_CC  = 8'hFE;  // rti tail with e set.
    localparam logic [7:0] PB_ONLY_PC = 8'h80;  // rti tail with e clear.

    // register ids on the direct load and read port.
    typedef enum logic [3:0] {
        REG_CC = 4'd0,
        REG_A  = 4'd1,
        REG_B  = 4'd2,
        REG_DP = 4'd3,
        REG_X  = 4'd4,
        REG_Y  = 4'd5,
        REG_U  = 4'd6,
        REG_PC = 4'd7,
        REG_S  = 4'd8
    } reg_id_e;

endpackage

`default_nettype wire
